// File: Bender.yml
package:
  name: eth_mid

export_include_dirs:
  - .

sources:
  - eth_mid_pkg.sv
  - slv_port.sv
  - ctrl_regs.sv
  - time_regs.sv
  - eth_mid_top.sv
  - target: test
    files:
      - eth_mid_chk.sv
      - tb_eth_mid_top.sv

// File: build.f
+incdir+.
eth_mid_pkg.sv
slv_port.sv
ctrl_regs.sv
time_regs.sv
eth_mid_top.sv
eth_mid_chk.sv
tb_eth_mid_top.sv

// File: ctrl_regs.sv
`timescale 1ns/10ps
`include "eth_mid_defines.svh"

module ctrl_regs import eth_mid_pkg::*; (
  input  logic          clk_125,
  input  logic          sys_rst,
  input  reg_acc_t      acc_i,
  input  logic          rec_intr_i,
  output logic [15:0]   rd_o,
  output logic          hit_o,
  output dma_cfg_t      dma_cfg_o,
  output logic [1:0]    dma_load_o,
  output tx_ptr_t [1:0] tx_wr_ptr_o,
  output logic          sys_intr_o
);

  localparam logic [31:0] LEN_RST  = `ETH_DMA_LEN_RST;
  localparam logic [31:0] ADR1_RST = `ETH_DMA1_ADDR_RST;
  localparam logic [31:0] ADR2_RST = `ETH_DMA2_ADDR_RST;

  logic [7:0]    dma_stat;
  dma_cfg_t      dma_cfg;
  logic [1:0]    dma_load;
  tx_ptr_t [1:0] tx_wr_ptr;
  logic [15:0]   wr_word;

  // ----------------------------------------
  // read mux in little-endian word order
  // ----------------------------------------
  always_comb begin
    rd_o  = 16'h0000;
    hit_o = 1'b1;
    case (acc_i.idx)
      `ETH_REG_DMA_STAT:  rd_o = {8'h00, dma_stat};
      `ETH_REG_DMA_LEN0:  rd_o = {dma_cfg.len[15:2], 2'b00};
      `ETH_REG_DMA_LEN1:  rd_o = {10'h000, dma_cfg.len[21:16]};
      `ETH_REG_DMA1_ADR0: rd_o = {dma_cfg.dma1_start[15:2], 2'b00};
      `ETH_REG_DMA1_ADR1: rd_o = dma_cfg.dma1_start[31:16];
      `ETH_REG_DMA2_ADR0: rd_o = {dma_cfg.dma2_start[15:2], 2'b00};
      `ETH_REG_DMA2_ADR1: rd_o = dma_cfg.dma2_start[31:16];
      `ETH_REG_TX0_WPTR:  rd_o = 16'(tx_wr_ptr[0]);
      `ETH_REG_TX1_WPTR:  rd_o = 16'(tx_wr_ptr[1]);
      default:            hit_o = 1'b0;
    endcase
  end

  // current word with the enabled lanes replaced
  assign wr_word = be_merge(rd_o, acc_i.wdat, acc_i.be);

  // ----------------------------------------
  // register update
  // ----------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      dma_stat           <= 8'h00;
      dma_cfg.len        <= LEN_RST[21:2];
      dma_cfg.dma1_start <= ADR1_RST[31:2];
      dma_cfg.dma2_start <= ADR2_RST[31:2];
      dma_load           <= 2'b00;
      tx_wr_ptr          <= '0;
    end else begin
      // strobes last one cycle
      dma_load <= 2'b00;
      if (acc_i.wr) begin
        case (acc_i.idx)
          `ETH_REG_DMA_STAT: dma_stat <= wr_word[7:0];
          `ETH_REG_DMA_LEN0: begin
            dma_cfg.len[15:2] <= wr_word[15:2];
            dma_load          <= 2'b11;
          end
          `ETH_REG_DMA_LEN1: begin
            dma_cfg.len[21:16] <= wr_word[5:0];
            dma_load           <= 2'b11;
          end
          `ETH_REG_DMA1_ADR0: begin
            dma_cfg.dma1_start[15:2] <= wr_word[15:2];
            dma_load[0]              <= 1'b1;
          end
          `ETH_REG_DMA1_ADR1: begin
            dma_cfg.dma1_start[31:16] <= wr_word;
            dma_load[0]               <= 1'b1;
          end
          `ETH_REG_DMA2_ADR0: begin
            dma_cfg.dma2_start[15:2] <= wr_word[15:2];
            dma_load[1]              <= 1'b1;
          end
          `ETH_REG_DMA2_ADR1: begin
            dma_cfg.dma2_start[31:16] <= wr_word;
            dma_load[1]               <= 1'b1;
          end
          `ETH_REG_TX0_WPTR: tx_wr_ptr[0] <= wr_word[`ETH_PTR_W-1:0];
          `ETH_REG_TX1_WPTR: tx_wr_ptr[1] <= wr_word[`ETH_PTR_W-1:0];
          default: ;
        endcase
      end
      // a new interrupt is never lost to a clearing write in the same cycle
      if (rec_intr_i) begin
        dma_stat[`ETH_INTR_BIT] <= 1'b1;
      end
    end
  end

  assign dma_cfg_o   = dma_cfg;
  assign dma_load_o  = dma_load;
  assign tx_wr_ptr_o = tx_wr_ptr;
  assign sys_intr_o  = dma_stat[`ETH_INTR_BIT];

endmodule

// File: eth_mid_chk.sv
`timescale 1ns/10ps
`include "eth_mid_defines.svh"

module eth_mid_chk (
  input logic                  clk_125,
  input logic                  sys_rst,
  input logic [1:0]            dma_load_o,
  input logic                  sys_intr_o,
  input logic [`ETH_CNT_W-1:0] global_counter_o
);

  // ----------------------------------------
  // load strobes
  // ----------------------------------------
  for (genvar i = 0; i < 2; i++) begin : g_load
    a_load_pulse: assert property (
      @(posedge clk_125) disable iff (sys_rst)
      dma_load_o[i] |=> !dma_load_o[i]
    ) else $error("dma_load_o[%0d] stayed high for more than one cycle", i);
  end

  // interrupt held low while in reset
  a_intr_rst: assert property (
    @(posedge clk_125)
    (sys_rst && $past(sys_rst)) |-> !sys_intr_o
  ) else $error("sys_intr_o high during reset");

  // ----------------------------------------
  // free-running counter
  // ----------------------------------------
  a_cnt_step: assert property (
    @(posedge clk_125) disable iff (sys_rst)
    !$past(sys_rst) |-> (global_counter_o == $past(global_counter_o) + 1'b1)
  ) else $error("global_counter_o did not advance by one");

endmodule

bind eth_mid_top eth_mid_chk eth_mid_chk_i (.*);

// File: eth_mid_defines.svh
`ifndef ETH_MID_DEFINES_SVH
`define ETH_MID_DEFINES_SVH

// ----------------------------------------
// widths
// ----------------------------------------
`define ETH_CNT_W 64
`define ETH_LT_W 48
`define ETH_LT_NUM 7
`define ETH_PTR_W 14

// subtracted from the counter on a local-time capture
`define ETH_CAPTURE_OFS 3

// dma reset values as byte addresses
`define ETH_DMA_LEN_RST 32'h0001_0000
`define ETH_DMA1_ADDR_RST 32'h1000_0000
`define ETH_DMA2_ADDR_RST 32'h1010_0000

// ----------------------------------------
// bar 0 register indices
// ----------------------------------------
`define ETH_REG_GCNT0 8'h02
`define ETH_REG_GCNT1 8'h03
`define ETH_REG_GCNT2 8'h04
`define ETH_REG_GCNT3 8'h05

`define ETH_REG_DMA_STAT 8'h08
`define ETH_REG_DMA_LEN0 8'h0a
`define ETH_REG_DMA_LEN1 8'h0b
`define ETH_REG_DMA1_ADR0 8'h10
`define ETH_REG_DMA1_ADR1 8'h11
`define ETH_REG_DMA2_ADR0 8'h14
`define ETH_REG_DMA2_ADR1 8'h15

`define ETH_REG_TX0_WPTR 8'h18
`define ETH_REG_TX1_WPTR 8'h19

// local time k, word w at LT_BASE + 3k + w
`define ETH_REG_LT_BASE 8'h80

// receive interrupt bit in dma status
`define ETH_INTR_BIT 3

`endif

// File: eth_mid_pkg.sv
`include "eth_mid_defines.svh"

package eth_mid_pkg;

  // ----------------------------------------
  // bus and register access
  // ----------------------------------------

  // one slave bus cycle as it arrives from the tlp engine
  typedef struct packed {
    logic [6:0]  bar;
    logic        ce;
    logic        we;
    logic [19:1] adr;
    logic [15:0] dat;
    logic [1:0]  sel;
  } slv_req_t;

  // decoded bar 0 access with data and enables in little-endian order
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [7:0]  idx;
    logic [15:0] wdat;
    logic [1:0]  be;
  } reg_acc_t;

  // ----------------------------------------
  // register contents
  // ----------------------------------------

  // word addresses with the low two bits implied zero
  typedef struct packed {
    logic [21:2] len;
    logic [31:2] dma1_start;
    logic [31:2] dma2_start;
  } dma_cfg_t;

  typedef logic [`ETH_LT_NUM-1:0][`ETH_LT_W-1:0] lt_bank_t;
  typedef logic [`ETH_LT_NUM-1:0] lt_req_t;
  typedef logic [`ETH_PTR_W-1:0] tx_ptr_t;

  // byte-enabled update of one 16-bit register word
  function automatic logic [15:0] be_merge(
    input logic [15:0] old_val,
    input logic [15:0] wdat,
    input logic [1:0]  be
  );
    logic [15:0] res;
    res[7:0]  = be[0] ? wdat[7:0] : old_val[7:0];
    res[15:8] = be[1] ? wdat[15:8] : old_val[15:8];
    return res;
  endfunction

endpackage

// File: eth_mid_top.sv
`timescale 1ns/10ps
`include "eth_mid_defines.svh"

module eth_mid_top import eth_mid_pkg::*; (
  input  logic                  clk_125,
  input  logic                  sys_rst,
  input  slv_req_t              slv_i,
  input  logic                  rec_intr_i,
  input  lt_req_t [1:0]         lt_req_i,
  output logic [15:0]           slv_dat_o,
  output logic                  sys_intr_o,
  output dma_cfg_t              dma_cfg_o,
  output logic [1:0]            dma_load_o,
  output tx_ptr_t [1:0]         tx_wr_ptr_o,
  output logic [`ETH_CNT_W-1:0] global_counter_o,
  output lt_bank_t              local_time_o
);

  reg_acc_t    acc;
  logic [15:0] ctrl_rd;
  logic        ctrl_hit;
  logic [15:0] time_rd;
  logic        time_hit;

  // bar 0 decode and registered read data
  slv_port slv_port_i (
    .clk_125    (clk_125),
    .sys_rst    (sys_rst),
    .slv_i      (slv_i),
    .ctrl_rd_i  (ctrl_rd),
    .ctrl_hit_i (ctrl_hit),
    .time_rd_i  (time_rd),
    .time_hit_i (time_hit),
    .acc_o      (acc),
    .slv_dat_o  (slv_dat_o)
  );

  // dma and transmit pointer registers
  ctrl_regs ctrl_regs_i (
    .clk_125     (clk_125),
    .sys_rst     (sys_rst),
    .acc_i       (acc),
    .rec_intr_i  (rec_intr_i),
    .rd_o        (ctrl_rd),
    .hit_o       (ctrl_hit),
    .dma_cfg_o   (dma_cfg_o),
    .dma_load_o  (dma_load_o),
    .tx_wr_ptr_o (tx_wr_ptr_o),
    .sys_intr_o  (sys_intr_o)
  );

  // global counter and local-time bank
  time_regs time_regs_i (
    .clk_125          (clk_125),
    .sys_rst          (sys_rst),
    .acc_i            (acc),
    .lt_req_i         (lt_req_i),
    .rd_o             (time_rd),
    .hit_o            (time_hit),
    .global_counter_o (global_counter_o),
    .local_time_o     (local_time_o)
  );

endmodule

// File: slv_port.sv
`timescale 1ns/10ps

module slv_port import eth_mid_pkg::*; (
  input  logic        clk_125,
  input  logic        sys_rst,
  input  slv_req_t    slv_i,
  input  logic [15:0] ctrl_rd_i,
  input  logic        ctrl_hit_i,
  input  logic [15:0] time_rd_i,
  input  logic        time_hit_i,
  output reg_acc_t    acc_o,
  output logic [15:0] slv_dat_o
);

  logic        bar0_cyc;
  logic        page0;
  logic [15:0] rd_mux;
  logic [15:0] rd_q;

  // bus carries byte 0 in the upper lane
  function automatic logic [15:0] swap_lanes(input logic [15:0] d);
    return {d[7:0], d[15:8]};
  endfunction

  // ----------------------------------------
  // access decode
  // ----------------------------------------
  assign bar0_cyc = slv_i.ce & slv_i.bar[0];

  // registers only live in the first 512 bytes
  assign page0 = (slv_i.adr[19:9] == 11'h000);

  always_comb begin
    acc_o.wr   = bar0_cyc & page0 & slv_i.we;
    acc_o.rd   = bar0_cyc & page0 & ~slv_i.we;
    acc_o.idx  = slv_i.adr[8:1];
    acc_o.wdat = swap_lanes(slv_i.dat);
    acc_o.be   = {slv_i.sel[0], slv_i.sel[1]};
  end

  // ----------------------------------------
  // read-back
  // ----------------------------------------

  // unclaimed index or upper page reads as zero
  always_comb begin
    rd_mux = 16'h0000;
    if (page0) begin
      if (ctrl_hit_i) begin
        rd_mux = ctrl_rd_i;
      end else if (time_hit_i) begin
        rd_mux = time_rd_i;
      end
    end
  end

  // held until the next bar 0 read
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      rd_q <= 16'h0000;
    end else if (bar0_cyc && !slv_i.we) begin
      rd_q <= swap_lanes(rd_mux);
    end
  end

  assign slv_dat_o = rd_q;

endmodule

// File: tb_eth_mid_top.sv
`timescale 1ns/10ps
`include "eth_mid_defines.svh"

module tb_eth_mid_top import eth_mid_pkg::*; ();

  localparam int OP_WR = 0, OP_RD = 1, OP_INTR = 2, OP_LTREQ = 3;

  logic                  clk_125 = 1'b0;
  logic                  sys_rst;
  slv_req_t              slv_i;
  logic                  rec_intr_i;
  lt_req_t [1:0]         lt_req_i;
  logic [15:0]           slv_dat_o;
  logic                  sys_intr_o;
  dma_cfg_t              dma_cfg_o;
  logic [1:0]            dma_load_o;
  tx_ptr_t [1:0]         tx_wr_ptr_o;
  logic [`ETH_CNT_W-1:0] global_counter_o;
  lt_bank_t              local_time_o;

  // stimulus table with one row per operation
  int          n_ops;
  int          t_op [80];
  logic [7:0]  t_idx [80];
  logic [15:0] t_dat [80];
  logic [1:0]  t_be [80];
  logic        t_flag [80];

  // little-endian view of every register word
  logic [15:0]           shadow [256];
  logic [`ETH_CNT_W-1:0] ref_cnt;
  logic [15:0]           lfsr = 16'd57;
  int                    cyc_cnt = 0;
  int                    cyc_limit = 0;

  eth_mid_top eth_mid_top_i (.*);

  always #5 clk_125 = ~clk_125;

  // cycles counted since reset
  always @(posedge clk_125) begin
    if (sys_rst) begin
      ref_cnt <= '0;
    end else begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  always @(posedge clk_125) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_limit != 0 && cyc_cnt > cyc_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cyc_limit);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [15:0] rand_word();
    logic [15:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < 16; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[14:0], fb};
    end
    return r;
  endfunction

  function automatic logic [15:0] swap(input logic [15:0] d);
    return {d[7:0], d[15:8]};
  endfunction

  // writable bits of each register word
  function automatic logic [15:0] wr_mask(input logic [7:0] idx);
    if (idx >= `ETH_REG_LT_BASE && idx < `ETH_REG_LT_BASE + 3 * `ETH_LT_NUM) return 16'hffff;
    case (idx)
      `ETH_REG_DMA_STAT: return 16'h00ff;
      `ETH_REG_DMA_LEN0, `ETH_REG_DMA1_ADR0, `ETH_REG_DMA2_ADR0: return 16'hfffc;
      `ETH_REG_DMA_LEN1: return 16'h003f;
      `ETH_REG_DMA1_ADR1, `ETH_REG_DMA2_ADR1: return 16'hffff;
      `ETH_REG_TX0_WPTR, `ETH_REG_TX1_WPTR: return 16'h3fff;
      default: return 16'h0000;
    endcase
  endfunction

  function automatic slv_req_t make_req(input logic we, input logic [7:0] idx,
                                        input logic [15:0] dat, input logic [1:0] sel);
    slv_req_t r;
    r     = '0;
    r.bar = 7'b000_0001;
    r.ce  = 1'b1;
    r.we  = we;
    r.adr = {11'h000, idx};
    r.dat = dat;
    r.sel = sel;
    return r;
  endfunction

  function automatic dma_cfg_t cfg_model();
    dma_cfg_t c;
    c.len        = {shadow[`ETH_REG_DMA_LEN1][5:0], shadow[`ETH_REG_DMA_LEN0][15:2]};
    c.dma1_start = {shadow[`ETH_REG_DMA1_ADR1], shadow[`ETH_REG_DMA1_ADR0][15:2]};
    c.dma2_start = {shadow[`ETH_REG_DMA2_ADR1], shadow[`ETH_REG_DMA2_ADR0][15:2]};
    return c;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) stop_on_error($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_cfg(input dma_cfg_t got, input dma_cfg_t exp);
    if (got !== exp) stop_on_error($sformatf("ERROR dma_cfg_o got 0x%h expected 0x%h", got, exp));
  endtask

  task automatic check_ptr(input string name, input tx_ptr_t got, input tx_ptr_t exp);
    if (got !== exp) stop_on_error($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_time(input string name, input logic [`ETH_LT_W-1:0] got,
                            input logic [`ETH_LT_W-1:0] exp);
    if (got !== exp) stop_on_error($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_cnt(input logic [`ETH_CNT_W-1:0] got,
                           input logic [`ETH_CNT_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERROR global_counter_o got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic add_op(input int op, input logic [7:0] idx, input logic [15:0] dat,
                        input logic [1:0] be, input logic flag);
    t_op[n_ops]   = op;
    t_idx[n_ops]  = idx;
    t_dat[n_ops]  = dat;
    t_be[n_ops]   = be;
    t_flag[n_ops] = flag;
    n_ops++;
  endtask

  // ----------------------------------------
  // bus and pulse operations
  // ----------------------------------------
  task automatic write_reg(input logic [7:0] idx, input logic [15:0] d, input logic [1:0] be);
    logic [15:0] m;
    logic [1:0]  exp_load;
    @(posedge clk_125);
    slv_i <= make_req(1'b1, idx, swap(d), {be[0], be[1]});
    @(posedge clk_125);
    slv_i <= '0;
    m = wr_mask(idx) & {{8{be[1]}}, {8{be[0]}}};
    shadow[idx] = (shadow[idx] & ~m) | (d & m);
    case (idx)
      `ETH_REG_DMA_LEN0, `ETH_REG_DMA_LEN1: exp_load = 2'b11;
      `ETH_REG_DMA1_ADR0, `ETH_REG_DMA1_ADR1: exp_load = 2'b01;
      `ETH_REG_DMA2_ADR0, `ETH_REG_DMA2_ADR1: exp_load = 2'b10;
      default: exp_load = 2'b00;
    endcase
    @(negedge clk_125);
    check_cfg(dma_cfg_o, cfg_model());
    check_ptr("tx_wr_ptr_o[0]", tx_wr_ptr_o[0], shadow[`ETH_REG_TX0_WPTR][13:0]);
    check_ptr("tx_wr_ptr_o[1]", tx_wr_ptr_o[1], shadow[`ETH_REG_TX1_WPTR][13:0]);
    check_word("dma_load_o", 16'(dma_load_o), 16'(exp_load));
    check_word("sys_intr_o", 16'(sys_intr_o), 16'(shadow[`ETH_REG_DMA_STAT][3]));
    for (int k = 0; k < `ETH_LT_NUM; k++) begin
      check_time($sformatf("local_time_o[%0d]", k), local_time_o[k],
                 {shadow[`ETH_REG_LT_BASE + 3 * k + 2], shadow[`ETH_REG_LT_BASE + 3 * k + 1],
                  shadow[`ETH_REG_LT_BASE + 3 * k]});
    end
    @(negedge clk_125);
    check_word("dma_load_o", 16'(dma_load_o), 16'h0000);
  endtask

  task automatic read_reg(input logic [7:0] idx, input logic [15:0] exp_le, input logic model);
    @(posedge clk_125);
    slv_i <= make_req(1'b0, idx, 16'h0000, 2'b11);
    @(posedge clk_125);
    slv_i <= '0;
    if (idx >= `ETH_REG_GCNT0 && idx <= `ETH_REG_GCNT3) begin
      exp_le = ref_cnt[16 * (idx - `ETH_REG_GCNT0) +: 16];
    end else if (model) begin
      exp_le = shadow[idx];
    end
    @(negedge clk_125);
    check_word($sformatf("slv_dat_o (index 0x%h)", idx), slv_dat_o, swap(exp_le));
  endtask

  // requests pulse together and captures follow one per idle edge
  task automatic request_times(input logic [13:0] mask);
    lt_req_t                pend;
    logic [`ETH_LT_W-1:0]   val;
    int                     k;
    @(posedge clk_125);
    lt_req_i[0] <= mask[6:0];
    lt_req_i[1] <= mask[13:7];
    @(posedge clk_125);
    lt_req_i <= '0;
    pend = mask[6:0] | mask[13:7];
    while (pend != '0) begin
      @(posedge clk_125);
      k = 0;
      while (!pend[k]) k++;
      pend[k] = 1'b0;
      val = ref_cnt[`ETH_LT_W-1:0] - `ETH_CAPTURE_OFS;
      for (int w = 0; w < 3; w++) shadow[`ETH_REG_LT_BASE + 3 * k + w] = val[16 * w +: 16];
      @(negedge clk_125);
      check_time($sformatf("local_time_o[%0d]", k), local_time_o[k], val);
      check_cnt(global_counter_o, ref_cnt);
    end
  endtask

  initial begin
    int rd_first;
    sys_rst    = 1'b1;
    slv_i      = '0;
    rec_intr_i = 1'b0;
    lt_req_i   = '0;
    n_ops      = 0;
    foreach (shadow[i]) shadow[i] = 16'h0000;
    shadow[`ETH_REG_DMA_LEN1]  = 16'(`ETH_DMA_LEN_RST >> 16);
    shadow[`ETH_REG_DMA1_ADR1] = 16'(`ETH_DMA1_ADDR_RST >> 16);
    shadow[`ETH_REG_DMA2_ADR1] = 16'(`ETH_DMA2_ADDR_RST >> 16);

    // reset values and unmapped indices
    add_op(OP_RD, `ETH_REG_DMA_STAT, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA_LEN0, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA_LEN1, 16'h0001, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA1_ADR0, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA1_ADR1, 16'h1000, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA2_ADR0, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA2_ADR1, 16'h1010, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_TX0_WPTR, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_TX1_WPTR, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, 8'h80, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, 8'h00, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, 8'h30, 16'h0000, 2'b11, 1'b0);
    add_op(OP_RD, 8'ha0, 16'h0000, 2'b11, 1'b0);
    // counter words
    for (int i = 0; i < 4; i++) add_op(OP_RD, `ETH_REG_GCNT0 + i, 16'h0000, 2'b11, 1'b1);
    add_op(OP_RD, `ETH_REG_GCNT0, 16'h0000, 2'b11, 1'b1);
    // dma config with one byte-select pattern after another
    for (int i = 0; i < 6; i++) begin
      add_op(OP_WR, `ETH_REG_DMA_LEN0 + 8'(i % 2 + (i >= 2 ? 6 : 0) + (i >= 4 ? 4 : 0)),
             16'h0000, 2'(i + 1), 1'b1);
    end
    add_op(OP_WR, `ETH_REG_DMA_LEN1, 16'h0000, 2'b00, 1'b1);
    rd_first = n_ops - 7;
    for (int i = rd_first; i < rd_first + 7; i++) begin
      add_op(OP_RD, t_idx[i], 16'h0000, 2'b11, 1'b1);
    end
    // transmit pointers
    add_op(OP_WR, `ETH_REG_TX0_WPTR, 16'h0000, 2'b11, 1'b1);
    add_op(OP_WR, `ETH_REG_TX1_WPTR, 16'h0000, 2'b11, 1'b1);
    add_op(OP_RD, `ETH_REG_TX0_WPTR, 16'h0000, 2'b11, 1'b1);
    add_op(OP_RD, `ETH_REG_TX1_WPTR, 16'h0000, 2'b11, 1'b1);
    // receive interrupt
    add_op(OP_INTR, 8'h00, 16'h0000, 2'b00, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA_STAT, 16'h0000, 2'b11, 1'b1);
    add_op(OP_WR, `ETH_REG_DMA_STAT, 16'h0001, 2'b11, 1'b0);
    add_op(OP_RD, `ETH_REG_DMA_STAT, 16'h0000, 2'b11, 1'b1);
    // local times and then a bus write over a captured one
    add_op(OP_LTREQ, 8'h00, {7'b100_0101, 7'b010_0100}, 2'b00, 1'b0);
    add_op(OP_LTREQ, 8'h00, {7'b000_0010, 7'b000_0000}, 2'b00, 1'b0);
    for (int i = 0; i < 3 * `ETH_LT_NUM; i++) begin
      add_op(OP_RD, 8'h80 + 8'(i), 16'h0000, 2'b11, 1'b1);
    end
    add_op(OP_WR, 8'h86, 16'h0000, 2'b11, 1'b1);
    add_op(OP_WR, 8'h87, 16'h0000, 2'b10, 1'b1);
    add_op(OP_RD, 8'h86, 16'h0000, 2'b11, 1'b1);
    add_op(OP_RD, 8'h87, 16'h0000, 2'b11, 1'b1);
    cyc_limit = n_ops * 4 + 100;

    repeat (8) @(posedge clk_125);
    sys_rst <= 1'b0;

    for (int i = 0; i < n_ops; i++) begin
      case (t_op[i])
        OP_WR: write_reg(t_idx[i], t_flag[i] ? rand_word() : t_dat[i], t_be[i]);
        OP_RD: read_reg(t_idx[i], t_dat[i], t_flag[i]);
        OP_INTR: begin
          @(posedge clk_125);
          rec_intr_i <= 1'b1;
          @(posedge clk_125);
          rec_intr_i <= 1'b0;
          shadow[`ETH_REG_DMA_STAT][`ETH_INTR_BIT] = 1'b1;
          @(negedge clk_125);
          check_word("sys_intr_o", 16'(sys_intr_o), 16'h0001);
        end
        default: request_times(t_dat[i][13:0]);
      endcase
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: time_regs.sv
`timescale 1ns/10ps
`include "eth_mid_defines.svh"

module time_regs import eth_mid_pkg::*; (
  input  logic                  clk_125,
  input  logic                  sys_rst,
  input  reg_acc_t              acc_i,
  input  lt_req_t [1:0]         lt_req_i,
  output logic [15:0]           rd_o,
  output logic                  hit_o,
  output logic [`ETH_CNT_W-1:0] global_counter_o,
  output lt_bank_t              local_time_o
);

  localparam int LT_WORDS = `ETH_LT_W / 16;
  localparam logic [7:0] LT_BASE = `ETH_REG_LT_BASE;
  localparam logic [`ETH_LT_W-1:0] CAP_OFS = `ETH_CAPTURE_OFS;

  logic [`ETH_CNT_W-1:0] gcnt;
  lt_bank_t              lt_bank;
  lt_req_t               lt_pend;
  lt_req_t               lt_pick;
  lt_req_t               lt_serve;
  logic                  bus_busy;
  logic [`ETH_LT_W-1:0]  cap_val;
  logic [15:0]           wr_word;
  logic [LT_WORDS-1:0]   lt_sel [`ETH_LT_NUM];

  // ----------------------------------------
  // capture arbitration
  // ----------------------------------------
  assign bus_busy = acc_i.wr | acc_i.rd;

  // lowest pending index only
  assign lt_pick  = lt_pend & (~lt_pend + 1'b1);
  assign lt_serve = bus_busy ? '0 : lt_pick;
  assign cap_val  = gcnt[`ETH_LT_W-1:0] - CAP_OFS;

  // ----------------------------------------
  // bus decode and read mux
  // ----------------------------------------
  always_comb begin
    rd_o  = 16'h0000;
    hit_o = 1'b1;
    case (acc_i.idx)
      `ETH_REG_GCNT0: rd_o = gcnt[15:0];
      `ETH_REG_GCNT1: rd_o = gcnt[31:16];
      `ETH_REG_GCNT2: rd_o = gcnt[47:32];
      `ETH_REG_GCNT3: rd_o = gcnt[63:48];
      default:        hit_o = 1'b0;
    endcase
    for (int k = 0; k < `ETH_LT_NUM; k++) begin
      for (int w = 0; w < LT_WORDS; w++) begin
        lt_sel[k][w] = (acc_i.idx == LT_BASE + 8'(LT_WORDS * k + w));
        if (lt_sel[k][w]) begin
          rd_o  = lt_bank[k][16*w +: 16];
          hit_o = 1'b1;
        end
      end
    end
  end

  assign wr_word = be_merge(rd_o, acc_i.wdat, acc_i.be);

  // ----------------------------------------
  // counter, pending set and local times
  // ----------------------------------------
  always_ff @(posedge clk_125) begin
    if (sys_rst) begin
      gcnt    <= '0;
      lt_pend <= '0;
      lt_bank <= '0;
    end else begin
      gcnt <= gcnt + 1'b1;
      // both transmitters share one pending set
      lt_pend <= (lt_pend & ~lt_serve) | lt_req_i[0] | lt_req_i[1];
      // capture only runs on idle cycles, so bus writes always take the word
      for (int k = 0; k < `ETH_LT_NUM; k++) begin
        if (lt_serve[k]) begin
          lt_bank[k] <= cap_val;
        end
        for (int w = 0; w < LT_WORDS; w++) begin
          if (acc_i.wr && lt_sel[k][w]) begin
            lt_bank[k][16*w +: 16] <= wr_word;
          end
        end
      end
    end
  end

  assign global_counter_o = gcnt;
  assign local_time_o     = lt_bank;

endmodule
